// File: dcache.f
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/mshr_queue.sv
rtl/dcache_top.sv
tests/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -o dcache_sim &&
./obj_dir/dcache_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }

// File: tests/dcache_tb.sv
// Data cache testbench
// Random loads and stores against a memory model, checked with a byte reference model

module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_lines = 24;
  localparam int limit   = 400;  // Cycles allowed for any single wait

  logic                                clock, reset;
  logic                                load_start, load_hit, store_valid, store_stall;
  logic [dcache_pkg::addr_w-1:0]       load_addr, store_addr, mem_addr;
  logic [dcache_pkg::word_w-1:0]       load_data, store_data;
  logic [3:0]                          store_bytes;
  logic [dcache_pkg::mem_tag_w-1:0]    mem_response, mem_tag;
  logic [dcache_pkg::line_w-1:0]       mem_wdata, mem_rdata;
  dcache_pkg::mem_cmd_e                mem_command;

  // Memory image, reference bytes per line, and lines the client wrote
  logic [63:0] mem_img  [8192];
  logic [63:0] ref_line [8192];
  bit          dirtied  [8192];
  logic [12:0] lines    [n_lines];
  logic [3:0]  sets     [4] = '{4'h1, 4'h6, 4'ha, 4'hd};  // Only four sets in use
  logic [12:0] evicted  [$];

  integer seed = 10946;
  int     errors = 0, checks = 0, fails = 0, test_num = 0, test_errors = 0;
  int     cyc = 0, slow = 0, wait_left = 0, next_free = 0;
  string  test_name;

  // Memory controller model state
  bit                   pending = 1'b0, held = 1'b0;
  dcache_pkg::mem_cmd_e held_cmd;
  logic [15:0]          held_addr;
  logic [63:0]          held_wdata;
  logic [3:0]           next_tag = 4'd1;
  logic [3:0]           ans_tag  [$];
  logic [63:0]          ans_data [$];
  int                   ans_due  [$];

  dcache_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Power-on line contents built from every line address bit
  function automatic logic [63:0] line_init(input logic [12:0] la);
    return {3'd5, la, 3'd3, ~la, 3'd6, la ^ 13'h1555, 3'd1, la + 13'd77};
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + r % (hi - lo + 1);
  endfunction

  function automatic logic [31:0] ref_word(input logic [15:0] a);
    return a[2] ? ref_line[a[15:3]][63:32] : ref_line[a[15:3]][31:0];
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Error in %s: %s", test_name, msg);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #5;  // Inputs change shortly after the edge
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    test_num++;
  endtask

  task automatic finish_test();
    if (errors != test_errors) fails++;
    $display("test %0d %s: %s, %0d errors", test_num, test_name,
             (errors == test_errors) ? "ok" : "failed", errors - test_errors);
  endtask

  // ----------------------------------------------------------
  // Client side
  // ----------------------------------------------------------
  // Retries one load until it hits and checks the word
  task automatic load_word(input logic [15:0] a, input bit expect_miss);
    int n;
    n = 0;
    load_start = 1'b1;
    load_addr  = a;
    #20;
    if (expect_miss) check_true(!load_hit, $sformatf("first load of %h hit", a));
    while (!load_hit && n < limit) begin
      next_cycle();
      #20;
      n++;
    end
    check_true(load_hit, $sformatf("load of %h never hit", a));
    if (load_hit) check_value($sformatf("load %h", a), 64'(ref_word(a)), 64'(load_data));
    next_cycle();
    load_start = 1'b0;
  endtask

  // Waits for room, stores one word and updates the reference bytes
  task automatic store_word(input logic [15:0] a, input logic [31:0] d, input logic [3:0] be);
    int n;
    int k;
    n = 0;
    while (store_stall && n < limit) begin
      next_cycle();
      n++;
    end
    check_true(!store_stall, "store_stall stayed high");
    if (!store_stall) begin
      store_valid = 1'b1;
      store_addr  = a;
      store_data  = d;
      store_bytes = be;
      for (int i = 0; i < 4; i++) begin
        k = (a[2] ? 32 : 0) + 8 * i;
        if (be[i]) ref_line[a[15:3]][k +: 8] = d[8*i +: 8];
      end
      dirtied[a[15:3]] = 1'b1;
      next_cycle();
      store_valid = 1'b0;
    end
  endtask

  // Waits until the memory side has been quiet for a while
  task automatic drain();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 8 && n < limit) begin
      next_cycle();
      #20;
      n++;
      quiet = (mem_command == dcache_pkg::bus_none && ans_due.size() == 0) ? quiet + 1 : 0;
    end
    check_true(quiet >= 8, "memory traffic did not stop");
    next_cycle();
  endtask

  // ----------------------------------------------------------
  // Memory controller model
  // ----------------------------------------------------------
  task automatic accept_command();
    logic [12:0] la;
    int slot;
    la = mem_addr[15:3];
    mem_response = next_tag;
    pending = 1'b0;
    if (mem_command == dcache_pkg::bus_store) begin
      check_true(dirtied[la], $sformatf("write-back of never written line %h", la));
      mem_img[la] = mem_wdata;
      evicted.push_back(la);
      slot = (next_free > cyc + 1) ? next_free : cyc + 1;  // Retires a cycle after issue
    end else begin
      slot = cyc + rand_range(2, 6);
      slot = (next_free > slot) ? next_free : slot;  // One retire per cycle in issue order
      ans_tag.push_back(next_tag);
      ans_data.push_back(mem_img[la]);
      ans_due.push_back(slot);
    end
    next_free = slot + 1;
    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
  endtask

  initial begin
    mem_response = '0;
    mem_tag      = '0;
    mem_rdata    = '0;
    forever begin
      next_cycle();
      cyc++;
      mem_response = '0;
      mem_tag      = '0;
      if (held) begin  // Unaccepted command must hold still
        check_true(mem_command == held_cmd && mem_addr == held_addr &&
                   mem_wdata == held_wdata, "memory command changed before acceptance");
      end
      held = 1'b0;
      if (ans_due.size() > 0 && ans_due[0] <= cyc) begin
        mem_tag   = ans_tag.pop_front();
        mem_rdata = ans_data.pop_front();
        void'(ans_due.pop_front());
      end
      if (!reset && mem_command != dcache_pkg::bus_none) begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = (slow != 0) ? rand_range(8, 12) : rand_range(0, 3);
        end
        if (wait_left == 0) begin
          accept_command();
        end else begin
          wait_left--;
          held       = 1'b1;
          held_cmd   = mem_command;
          held_addr  = mem_addr;
          held_wdata = mem_wdata;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [15:0] a;
    int s;
    int i;
    reset       = 1'b1;
    load_start  = 1'b0;
    load_addr   = '0;
    store_valid = 1'b0;
    store_addr  = '0;
    store_data  = '0;
    store_bytes = '0;
    for (int j = 0; j < 8192; j++) begin
      mem_img[j]  = line_init(13'(j));
      ref_line[j] = mem_img[j];
      dirtied[j]  = 1'b0;
    end
    for (int j = 0; j < n_lines; j++) lines[j] = {9'(7 + 29 * j), sets[j % 4]};
    repeat (8) @(posedge clock);
    #5;
    reset = 1'b0;
    next_cycle();

    start_test("reset_and_cold_loads");
    check_true(mem_command == dcache_pkg::bus_none && !store_stall, "queue busy after reset");
    for (int j = 0; j < n_lines; j++) load_word({lines[j], 1'(j % 2), 2'b00}, 1'b1);
    finish_test();

    start_test("random_traffic");
    for (int k = 0; k < 300; k++) begin
      a = {lines[rand_range(0, n_lines - 1)], 1'(rand_range(0, 1)), 2'b00};
      if (rand_range(0, 1) == 1) store_word(a, 32'($random(seed)), 4'(rand_range(1, 15)));
      load_word(a, 1'b0);
    end
    finish_test();

    start_test("store_miss_merge");
    for (int k = 0; k < 4; k++) begin
      s = rand_range(0, 15);
      // Two other lines take both ways of the set
      load_word({lines[s + 4], 3'b000}, 1'b0);
      load_word({lines[s + 8], 3'b000}, 1'b0);
      load_word({lines[s + 4], 3'b000}, 1'b0);  // Load hits leave the LRU bit alone
      a = {lines[s], 1'(rand_range(0, 1)), 2'b00};
      store_word(a, 32'($random(seed)), 4'(rand_range(1, 14)));
      load_word(a, 1'b1);
    end
    finish_test();

    start_test("dirty_write_back");
    drain();
    evicted.delete();
    s = rand_range(0, 15);
    for (int k = 0; k < 3; k++) begin
      store_word({lines[s + 4 * k], 3'b000}, 32'($random(seed)), 4'hf);
      load_word({lines[s + 4 * k], 3'b000}, 1'b0);
    end
    drain();
    check_true(evicted.size() > 0, "no dirty line was written back");
    foreach (evicted[j]) begin
      check_value($sformatf("memory line %h", evicted[j]), ref_line[evicted[j]],
                  mem_img[evicted[j]]);
    end
    finish_test();

    start_test("back_pressure");
    slow = 1;
    i = 0;
    while (!store_stall && i < n_lines) begin
      store_word({lines[i], 1'(rand_range(0, 1)), 2'b00}, 32'($random(seed)),
                 4'(rand_range(1, 15)));
      i++;
    end
    check_true(store_stall, "store_stall never rose");
    slow = 0;
    finish_test();

    start_test("drain_and_final_loads");
    drain();
    for (int j = 0; j < n_lines; j++) begin
      load_word({lines[j], 3'b000}, 1'b0);
      load_word({lines[j], 3'b100}, 1'b0);
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_num, fails, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/dcache_top.sv
// Write-back data cache top level
// Cache array and miss queue wired to the client and the memory controller

module dcache_top #(
  parameter int num_sets   = 16,
  parameter int mshr_depth = 8
) (
  input  logic                              clock,
  input  logic                              reset,

  // Load port
  input  logic                              load_start,
  input  logic [dcache_pkg::addr_w-1:0]     load_addr,
  output logic                              load_hit,
  output logic [dcache_pkg::word_w-1:0]     load_data,

  // Store port
  input  logic                              store_valid,
  input  logic [dcache_pkg::addr_w-1:0]     store_addr,
  input  logic [dcache_pkg::word_w-1:0]     store_data,
  input  logic [3:0]                        store_bytes,
  output logic                              store_stall,

  // Memory controller
  output dcache_pkg::mem_cmd_e              mem_command,
  output logic [dcache_pkg::addr_w-1:0]     mem_addr,
  output logic [dcache_pkg::line_w-1:0]     mem_wdata,
  input  logic [dcache_pkg::mem_tag_w-1:0]  mem_response,
  input  logic [dcache_pkg::mem_tag_w-1:0]  mem_tag,
  input  logic [dcache_pkg::line_w-1:0]     mem_rdata
);

  // Array to queue
  logic                               load_miss;
  logic [dcache_pkg::line_addr_w-1:0] load_line;
  logic                               store_miss;
  logic [dcache_pkg::line_addr_w-1:0] store_line;
  logic [dcache_pkg::line_w-1:0]      store_wdata;
  logic [7:0]                         store_wbytes;
  logic                               evict_valid;
  logic [dcache_pkg::line_addr_w-1:0] evict_line;
  logic [dcache_pkg::line_w-1:0]      evict_data;

  // Queue to array
  logic                               refill_en;
  logic [dcache_pkg::line_addr_w-1:0] refill_line;
  logic [dcache_pkg::line_w-1:0]      refill_data;
  logic [7:0]                         refill_bytes;
  logic                               refill_dirty;

  dcache_array #(.num_sets(num_sets)) u_array (
    .clock, .reset,
    .load_start, .load_addr, .load_hit, .load_data, .load_miss, .load_line,
    .store_valid, .store_addr, .store_data, .store_bytes,
    .store_miss, .store_line, .store_wdata, .store_wbytes,
    .refill_en, .refill_line, .refill_data, .refill_bytes, .refill_dirty,
    .evict_valid, .evict_line, .evict_data
  );

  mshr_queue #(.mshr_depth(mshr_depth)) u_mshr (
    .clock, .reset,
    .load_miss, .load_line,
    .store_miss, .store_line, .store_wdata, .store_wbytes,
    .evict_valid, .evict_line, .evict_data,
    .store_stall,
    .mem_command, .mem_addr, .mem_wdata,
    .mem_response, .mem_tag, .mem_rdata,
    .refill_en, .refill_line, .refill_data, .refill_bytes, .refill_dirty
  );

endmodule

// File: rtl/mshr_queue.sv
// Circular miss status queue between the cache and the memory controller
// Allocates misses and write-backs, issues in order, retires into refills

module mshr_queue #(
  parameter int mshr_depth = 8
) (
  input  logic                                clock,
  input  logic                                reset,

  // Misses and victims from the array
  input  logic                                load_miss,
  input  logic [dcache_pkg::line_addr_w-1:0]  load_line,
  input  logic                                store_miss,
  input  logic [dcache_pkg::line_addr_w-1:0]  store_line,
  input  logic [dcache_pkg::line_w-1:0]       store_wdata,
  input  logic [7:0]                          store_wbytes,
  input  logic                                evict_valid,
  input  logic [dcache_pkg::line_addr_w-1:0]  evict_line,
  input  logic [dcache_pkg::line_w-1:0]       evict_data,

  output logic                                store_stall,

  // Memory controller
  output dcache_pkg::mem_cmd_e                mem_command,
  output logic [dcache_pkg::addr_w-1:0]       mem_addr,
  output logic [dcache_pkg::line_w-1:0]       mem_wdata,
  input  logic [dcache_pkg::mem_tag_w-1:0]    mem_response,
  input  logic [dcache_pkg::mem_tag_w-1:0]    mem_tag,
  input  logic [dcache_pkg::line_w-1:0]       mem_rdata,

  // Refill into the array
  output logic                                refill_en,
  output logic [dcache_pkg::line_addr_w-1:0]  refill_line,
  output logic [dcache_pkg::line_w-1:0]       refill_data,
  output logic [7:0]                          refill_bytes,
  output logic                                refill_dirty
);

  localparam int ptr_w = $clog2(mshr_depth);
  localparam logic [ptr_w:0] stall_level = (ptr_w+1)'(mshr_depth - 3);

  // Entry storage
  dcache_pkg::mem_cmd_e                           ent_cmd [mshr_depth];
  logic [mshr_depth-1:0][dcache_pkg::line_addr_w-1:0] ent_line;
  logic [mshr_depth-1:0][dcache_pkg::line_w-1:0]  ent_data;
  logic [mshr_depth-1:0][7:0]                     ent_bytes;
  logic [mshr_depth-1:0]                          ent_dirty;
  logic [mshr_depth-1:0]                          ent_issued;
  logic [mshr_depth-1:0][dcache_pkg::mem_tag_w-1:0] ent_tag;

  // Pointers carry one extra wrap bit
  logic [ptr_w:0] head_q, issue_q, tail_q;
  logic [ptr_w:0] used_cnt;
  logic [ptr_w-1:0] head_idx, issue_idx;

  // Up to three allocations per cycle
  logic                                   req_v     [3];
  dcache_pkg::mem_cmd_e                   req_cmd   [3];
  logic [dcache_pkg::line_addr_w-1:0]     req_line  [3];
  logic [dcache_pkg::line_w-1:0]          req_data  [3];
  logic [7:0]                             req_bytes [3];
  logic                                   req_dirty [3];
  logic [ptr_w:0]                         slot      [4];

  logic issue_ok;
  logic accept;
  logic retire;

  assign head_idx  = head_q[ptr_w-1:0];
  assign issue_idx = issue_q[ptr_w-1:0];

  // Fewer than three free entries
  assign used_cnt    = tail_q - head_q;
  assign store_stall = used_cnt > stall_level;

  // ----------------------------------------------------------
  // Allocation: load miss, store miss, write-back
  // ----------------------------------------------------------
  always_comb begin
    req_v[0]     = load_miss & ~store_stall;  // Dropped when short of room
    req_cmd[0]   = dcache_pkg::bus_load;
    req_line[0]  = load_line;
    req_data[0]  = '0;
    req_bytes[0] = '0;
    req_dirty[0] = 1'b0;

    req_v[1]     = store_miss;
    req_cmd[1]   = dcache_pkg::bus_load;  // Write-allocate fetch
    req_line[1]  = store_line;
    req_data[1]  = store_wdata;
    req_bytes[1] = store_wbytes;
    req_dirty[1] = 1'b1;

    req_v[2]     = evict_valid;
    req_cmd[2]   = dcache_pkg::bus_store;
    req_line[2]  = evict_line;
    req_data[2]  = evict_data;
    req_bytes[2] = '0;
    req_dirty[2] = 1'b0;

    slot[0] = tail_q;
    for (int i = 0; i < 3; i++) begin
      slot[i+1] = slot[i] + {{ptr_w{1'b0}}, req_v[i]};
    end
  end

  // ----------------------------------------------------------
  // Issue to memory
  // ----------------------------------------------------------
  assign issue_ok = (issue_q != tail_q) && !ent_issued[issue_idx];
  assign accept   = issue_ok && (mem_response != '0);

  always_comb begin
    if (issue_ok) begin
      mem_command = ent_cmd[issue_idx];
      mem_addr    = {ent_line[issue_idx], {dcache_pkg::offset_w{1'b0}}};
      mem_wdata   = ent_data[issue_idx];
    end else begin
      mem_command = dcache_pkg::bus_none;
      mem_addr    = '0;
      mem_wdata   = '0;
    end
  end

  // ----------------------------------------------------------
  // Retire from the head
  // ----------------------------------------------------------
  // Stores leave a cycle after issue, loads wait for their tag
  assign retire = (head_q != tail_q) && ent_issued[head_idx] &&
                  (ent_cmd[head_idx] == dcache_pkg::bus_store ||
                   (ent_cmd[head_idx] == dcache_pkg::bus_load &&
                    mem_tag == ent_tag[head_idx]));

  assign refill_en    = retire && ent_cmd[head_idx] == dcache_pkg::bus_load;
  assign refill_line  = ent_line[head_idx];
  assign refill_bytes = ent_bytes[head_idx];
  assign refill_dirty = ent_dirty[head_idx];

  always_comb begin
    for (int b = 0; b < 8; b++) begin  // Store bytes laid over memory data
      refill_data[8*b +: 8] = (ent_dirty[head_idx] && ent_bytes[head_idx][b])
                            ? ent_data[head_idx][8*b +: 8]
                            : mem_rdata[8*b +: 8];
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      issue_q <= '0;
      tail_q  <= '0;
    end else begin
      head_q  <= head_q + {{ptr_w{1'b0}}, retire};
      issue_q <= issue_q + {{ptr_w{1'b0}}, accept};
      tail_q  <= slot[3];
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < 3; i++) begin
      if (req_v[i]) begin
        ent_cmd[slot[i][ptr_w-1:0]]    <= req_cmd[i];
        ent_line[slot[i][ptr_w-1:0]]   <= req_line[i];
        ent_data[slot[i][ptr_w-1:0]]   <= req_data[i];
        ent_bytes[slot[i][ptr_w-1:0]]  <= req_bytes[i];
        ent_dirty[slot[i][ptr_w-1:0]]  <= req_dirty[i];
        ent_issued[slot[i][ptr_w-1:0]] <= 1'b0;
      end
    end
    if (accept) begin
      ent_tag[issue_idx]    <= mem_response;  // Controller's transaction tag
      ent_issued[issue_idx] <= 1'b1;
    end
  end

endmodule

// File: rtl/dcache_array.sv
// Two-way set associative cache storage with one LRU bit per set
// Combinational load and store lookup, store hit write, refill and victim pick

module dcache_array #(
  parameter int num_sets = 16
) (
  input  logic                                clock,
  input  logic                                reset,

  // Load port
  input  logic                                load_start,
  input  logic [dcache_pkg::addr_w-1:0]       load_addr,
  output logic                                load_hit,
  output logic [dcache_pkg::word_w-1:0]       load_data,
  output logic                                load_miss,
  output logic [dcache_pkg::line_addr_w-1:0]  load_line,

  // Store port
  input  logic                                store_valid,
  input  logic [dcache_pkg::addr_w-1:0]       store_addr,
  input  logic [dcache_pkg::word_w-1:0]       store_data,
  input  logic [3:0]                          store_bytes,
  output logic                                store_miss,
  output logic [dcache_pkg::line_addr_w-1:0]  store_line,
  output logic [dcache_pkg::line_w-1:0]       store_wdata,
  output logic [7:0]                          store_wbytes,

  // Refill from the miss queue
  input  logic                                refill_en,
  input  logic [dcache_pkg::line_addr_w-1:0]  refill_line,
  input  logic [dcache_pkg::line_w-1:0]       refill_data,
  input  logic [7:0]                          refill_bytes,
  input  logic                                refill_dirty,

  // Dirty victim going out
  output logic                                evict_valid,
  output logic [dcache_pkg::line_addr_w-1:0]  evict_line,
  output logic [dcache_pkg::line_w-1:0]       evict_data
);

  localparam int set_bits = $clog2(num_sets);
  localparam int tag_bits = dcache_pkg::line_addr_w - set_bits;
  localparam int word_w   = dcache_pkg::word_w;

  // Storage, set major, two ways per set
  logic [num_sets-1:0][1:0][dcache_pkg::line_w-1:0] data_q, data_d;
  logic [num_sets-1:0][1:0][tag_bits-1:0]           tags_q, tags_d;
  logic [num_sets-1:0][1:0]                         valid_q, valid_d;
  logic [num_sets-1:0][1:0]                         dirty_q, dirty_d;
  logic [num_sets-1:0]                              lru_q, lru_d;  // Way to replace next

  logic [set_bits-1:0] ld_set, st_set, rf_set;
  logic [tag_bits-1:0] ld_tag, st_tag, rf_tag;
  logic                ld_hit, st_hit, rf_hit;
  logic                ld_way, st_way, rf_hit_way;
  logic                rf_has_free;
  logic                rf_free_way;
  logic                victim;
  logic                rf_way;

  // Returns {hit, way} for one set
  function automatic logic [1:0] probe(
    input logic [1:0]               vld,
    input logic [1:0][tag_bits-1:0] tags,
    input logic [tag_bits-1:0]      tag
  );
    logic [1:0] res;
    res = 2'b00;
    for (int w = 0; w < 2; w++) begin
      if (vld[w] && tags[w] == tag) begin
        res = {1'b1, w[0]};
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Address split and lookups
  // ----------------------------------------------------------
  assign load_line  = load_addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w];
  assign store_line = store_addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w];

  assign {ld_tag, ld_set} = load_line;
  assign {st_tag, st_set} = store_line;
  assign {rf_tag, rf_set} = refill_line;

  assign {ld_hit, ld_way}     = probe(valid_q[ld_set], tags_q[ld_set], ld_tag);
  assign {st_hit, st_way}     = probe(valid_q[st_set], tags_q[st_set], st_tag);
  assign {rf_hit, rf_hit_way} = probe(valid_q[rf_set], tags_q[rf_set], rf_tag);

  assign rf_has_free = ~&valid_q[rf_set];
  assign rf_free_way = valid_q[rf_set][0];  // First invalid way

  // Load result, word picked by address bit 2
  assign load_hit  = load_start & ld_hit;
  assign load_miss = load_start & ~ld_hit;
  assign load_data = load_addr[dcache_pkg::offset_w-1]
                   ? data_q[ld_set][ld_way][word_w +: word_w]
                   : data_q[ld_set][ld_way][0 +: word_w];

  // Store word and mask placed into the line
  assign store_wdata  = store_addr[dcache_pkg::offset_w-1]
                      ? {store_data, {word_w{1'b0}}}
                      : {{word_w{1'b0}}, store_data};
  assign store_wbytes = store_addr[dcache_pkg::offset_w-1]
                      ? {store_bytes, 4'b0000}
                      : {4'b0000, store_bytes};
  assign store_miss   = store_valid & ~st_hit;

  // ----------------------------------------------------------
  // Next state: store hit first, then refill
  // ----------------------------------------------------------
  always_comb begin
    data_d      = data_q;
    tags_d      = tags_q;
    valid_d     = valid_q;
    dirty_d     = dirty_q;
    lru_d       = lru_q;
    evict_valid = 1'b0;

    if (store_valid && st_hit) begin
      for (int b = 0; b < 8; b++) begin
        if (store_wbytes[b]) begin
          data_d[st_set][st_way][8*b +: 8] = store_wdata[8*b +: 8];
        end
      end
      dirty_d[st_set][st_way] = 1'b1;
      lru_d[st_set]           = ~st_way;
    end

    // Victim seen after the store, so a same cycle store is written back
    victim     = lru_d[rf_set];
    rf_way     = victim;
    evict_line = {tags_d[rf_set][victim], rf_set};
    evict_data = data_d[rf_set][victim];

    if (refill_en) begin
      if (rf_hit) begin
        rf_way = rf_hit_way;
        if (refill_dirty) begin  // Store miss landing on a present line
          for (int b = 0; b < 8; b++) begin
            if (refill_bytes[b]) begin
              data_d[rf_set][rf_way][8*b +: 8] = refill_data[8*b +: 8];
            end
          end
          dirty_d[rf_set][rf_way] = 1'b1;
        end
      end else begin
        if (rf_has_free) begin
          rf_way = rf_free_way;
        end else begin
          evict_valid = dirty_d[rf_set][victim];
        end
        valid_d[rf_set][rf_way] = 1'b1;
        tags_d[rf_set][rf_way]  = rf_tag;
        data_d[rf_set][rf_way]  = refill_data;
        dirty_d[rf_set][rf_way] = refill_dirty;
      end
      lru_d[rf_set] = ~rf_way;
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      lru_q   <= lru_d;
    end
  end

  always_ff @(posedge clock) begin
    data_q <= data_d;
    tags_q <= tags_d;
  end

endmodule

// File: rtl/dcache_pkg.sv
// Data cache shared definitions
// Address split widths and the memory bus command encoding

package dcache_pkg;

  // ----------------------------------------------------------
  // Address and data widths
  // ----------------------------------------------------------
  localparam int addr_w   = 16;  // Byte address
  localparam int word_w   = 32;  // Load and store data
  localparam int line_w   = 64;  // Cache line and memory bus

  // Byte offset inside a line, bit 2 picks the word
  localparam int offset_w = 3;

  localparam int index_w  = 4;   // Address bits 6 to 3
  localparam int tag_w    = 9;   // Address bits 15 to 7

  // Tag followed by index
  localparam int line_addr_w = addr_w - offset_w;

  // Memory transaction tag, zero means no transaction
  localparam int mem_tag_w = 4;

  // ----------------------------------------------------------
  // Memory controller command
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } mem_cmd_e;

endpackage
